/* include/mm_ram_consts.svh */
// ==========================================================================
// widths, address map and magic values shared by the memory wrapper and
// its testbench, pulled in with `include where needed
// ==========================================================================

`ifndef MM_RAM_CONSTS_SVH
`define MM_RAM_CONSTS_SVH

// memory geometry
`define RAM_ADDR_WIDTH    16
`define INSTR_RDATA_WIDTH 128
`define DATA_WIDTH        32
`define BE_WIDTH          4

// pseudo peripheral address map
`define ADDR_STATUS       32'h2000_0000
`define ADDR_EXIT         32'h2000_0004
`define ADDR_TIMER_MASK   32'h1500_0000
`define ADDR_TIMER_CNT    32'h1500_0004

// values written by the test program to the status register
`define STATUS_PASS_VALUE 32'd123456789
`define STATUS_FAIL_VALUE 32'd1

// timer mask bit, and the id an acknowledge has to carry
`define TIMER_IRQ_ID      3
`define IRQ_ID_WIDTH      5

`define ERR_RDATA         32'hDEAD_BEEF

`endif

/* rtl/mm_ram_pkg.sv */
// ==========================================================================
// types for the memory wrapper, imported by every RTL block
// ==========================================================================

`default_nettype none

`include "mm_ram_consts.svh"

package mm_ram_pkg;

    // byte address inside the RAM
    typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

    typedef logic [`DATA_WIDTH-1:0] data_word_t;

    typedef logic [`BE_WIDTH-1:0] byte_en_t;

    // one instruction fetch, lowest address in the low byte
    typedef logic [`INSTR_RDATA_WIDTH-1:0] instr_word_t;

    // full core address on the data bus
    typedef logic [31:0] bus_addr_t;

    typedef logic [`IRQ_ID_WIDTH-1:0] irq_id_t;

    // source of the data returned with rvalid
    typedef enum logic {
        SEL_RAM = 1'b0,
        SEL_ERR = 1'b1
    } rdata_sel_e;

endpackage

`default_nettype wire

/* rtl/dp_ram.sv */
// ==========================================================================
// byte array with a wide read-only fetch port and a byte-enabled data port,
// both synchronous with one cycle of read latency
// ==========================================================================

`default_nettype none
`timescale 1ns/100ps

`include "mm_ram_consts.svh"

module dp_ram import mm_ram_pkg::*; (
    input  wire logic        clk_i,

    // instruction fetch port
    input  wire logic        instr_req_i,
    input  wire ram_addr_t   instr_addr_i,
    output      instr_word_t instr_rdata_o,

    // data port
    input  wire logic        data_req_i,
    input  wire ram_addr_t   data_addr_i,
    input  wire logic        data_we_i,
    input  wire byte_en_t    data_be_i,
    input  wire data_word_t  data_wdata_i,
    output      data_word_t  data_rdata_o
);

    localparam int MEM_BYTES   = 2 ** `RAM_ADDR_WIDTH;
    localparam int INSTR_BYTES = `INSTR_RDATA_WIDTH / 8;

    logic [7:0] mem [0:MEM_BYTES-1];

    logic data_rd;
    logic data_wr;

    assign data_rd = data_req_i & ~data_we_i;
    assign data_wr = data_req_i & data_we_i;

    // byte writes from the data port
    always_ff @(posedge clk_i) begin
        if (data_wr) begin
            for (int i = 0; i < `BE_WIDTH; i++) begin
                if (data_be_i[i]) begin
                    mem[data_addr_i + ram_addr_t'(i)] <= data_wdata_i[8*i +: 8];
                end
            end
        end
    end

    // data read, register holds zero when the cycle had no read
    always_ff @(posedge clk_i) begin
        if (data_rd) begin
            for (int i = 0; i < `BE_WIDTH; i++) begin
                data_rdata_o[8*i +: 8] <= mem[data_addr_i + ram_addr_t'(i)];
            end
        end else begin
            data_rdata_o <= '0;
        end
    end

    // fetch 16 consecutive bytes, address wraps at the top of the array
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_addr_i + ram_addr_t'(i)];
            end
        end else begin
            instr_rdata_o <= '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/mm_addr_decoder.sv */
// ==========================================================================
// splits data requests between RAM, timer and test status registers;
// the status pulses are combinational and last only for the request cycle
// ==========================================================================

`default_nettype none
`timescale 1ns/100ps

`include "mm_ram_consts.svh"

module mm_addr_decoder import mm_ram_pkg::*; (
    input  wire logic       data_req_i,
    input  wire logic       data_we_i,
    input  wire bus_addr_t  data_addr_i,
    input  wire byte_en_t   data_be_i,
    input  wire data_word_t data_wdata_i,

    // toward the RAM data port
    output      logic       ram_req_o,
    output      ram_addr_t  ram_addr_o,
    output      logic       ram_we_o,
    output      byte_en_t   ram_be_o,
    output      data_word_t ram_wdata_o,

    // timer register writes
    output      logic       timer_mask_we_o,
    output      logic       timer_cnt_we_o,
    output      data_word_t timer_wdata_o,

    output      rdata_sel_e rdata_sel_o,

    output      logic       tests_passed_o,
    output      logic       tests_failed_o,
    output      logic       exit_valid_o,
    output      data_word_t exit_value_o
);

    logic ram_hit;
    logic wr_req;

    // everything below 2**RAM_ADDR_WIDTH lands in RAM
    assign ram_hit = (data_addr_i[31:`RAM_ADDR_WIDTH] == '0);
    assign wr_req  = data_req_i & data_we_i;

    always_comb begin
        ram_req_o       = 1'b0;
        ram_addr_o      = '0;
        ram_we_o        = 1'b0;
        ram_be_o        = '0;
        ram_wdata_o     = '0;
        timer_mask_we_o = 1'b0;
        timer_cnt_we_o  = 1'b0;
        timer_wdata_o   = '0;
        rdata_sel_o     = SEL_RAM;
        tests_passed_o  = 1'b0;
        tests_failed_o  = 1'b0;
        exit_valid_o    = 1'b0;
        exit_value_o    = '0;

        if (data_req_i && ram_hit) begin
            // word aligned, byte lanes picked by the enables
            ram_req_o   = 1'b1;
            ram_addr_o  = {data_addr_i[`RAM_ADDR_WIDTH-1:2], 2'b00};
            ram_we_o    = data_we_i;
            ram_be_o    = data_be_i;
            ram_wdata_o = data_wdata_i;
        end else if (wr_req) begin
            if (data_addr_i == `ADDR_TIMER_MASK) begin
                timer_mask_we_o = 1'b1;
                timer_wdata_o   = data_wdata_i;
            end else if (data_addr_i == `ADDR_TIMER_CNT) begin
                timer_cnt_we_o = 1'b1;
                timer_wdata_o  = data_wdata_i;
            end else if (data_addr_i == `ADDR_STATUS) begin
                // any other value on the status register is ignored
                tests_passed_o = (data_wdata_i == `STATUS_PASS_VALUE);
                tests_failed_o = (data_wdata_i == `STATUS_FAIL_VALUE);
            end else if (data_addr_i == `ADDR_EXIT) begin
                exit_valid_o = 1'b1;
                exit_value_o = data_wdata_i;
            end
            // unmapped writes are dropped
        end else if (data_req_i) begin
            // peripherals are write only, so reads here are errors
            rdata_sel_o = SEL_ERR;
        end
    end

endmodule

`default_nettype wire

/* rtl/tb_timer.sv */
// ==========================================================================
// countdown timer for test timeouts; load the mask, then the count, and
// the interrupt fires when the count runs out with mask bit 3 set
// ==========================================================================

`default_nettype none
`timescale 1ns/100ps

`include "mm_ram_consts.svh"

module tb_timer import mm_ram_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_ni,

    // register writes from the decoder
    input  wire logic       mask_we_i,
    input  wire logic       cnt_we_i,
    input  wire data_word_t wdata_i,

    // interrupt handshake with the core
    input  wire logic       irq_ack_i,
    input  wire irq_id_t    irq_id_i,
    output      logic       irq_o
);

    data_word_t mask_q;
    data_word_t cnt_q;
    logic       irq_q;
    logic       ack_timer;

    assign ack_timer = irq_ack_i && (irq_id_i == irq_id_t'(`TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else if (mask_we_i) begin
            mask_q <= wdata_i;
        end else if (cnt_we_i) begin
            cnt_q <= wdata_i;
        end else begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end

            // count goes 1 -> 0 on this edge
            if (cnt_q == data_word_t'(1) && mask_q[`TIMER_IRQ_ID]) begin
                irq_q <= 1'b1;
            end

            // ack wins over a new expiry in the same cycle
            if (ack_timer) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_o = irq_q;

endmodule

`default_nettype wire

/* rtl/data_resp_ctrl.sv */
// ==========================================================================
// data port handshake: grant in the request cycle, rvalid and read data
// one cycle later, picking the word from RAM or the error pattern
// ==========================================================================

`default_nettype none
`timescale 1ns/100ps

`include "mm_ram_consts.svh"

module data_resp_ctrl import mm_ram_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_ni,

    input  wire logic       data_req_i,
    input  wire rdata_sel_e rdata_sel_i,
    input  wire data_word_t ram_rdata_i,

    output      logic       data_gnt_o,
    output      logic       data_rvalid_o,
    output      data_word_t data_rdata_o
);

    logic       rvalid_q;
    rdata_sel_e rdata_sel_q;

    // no stalls, every request is taken at once
    assign data_gnt_o = data_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q    <= 1'b0;
            rdata_sel_q <= SEL_RAM;
        end else begin
            rvalid_q    <= data_req_i;
            rdata_sel_q <= rdata_sel_i;
        end
    end

    assign data_rvalid_o = rvalid_q;

    // RAM register already reads zero after a write or an idle cycle
    always_comb begin
        data_rdata_o = '0;
        if (rvalid_q) begin
            if (rdata_sel_q == SEL_ERR) begin
                data_rdata_o = `ERR_RDATA;
            end else begin
                data_rdata_o = ram_rdata_i;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mm_ram.sv */
// ==========================================================================
// memory and pseudo peripheral wrapper for simulating a small RISC-V core;
// instruction and data ports answer in one cycle without stalls
// ==========================================================================

`default_nettype none
`timescale 1ns/100ps

module mm_ram import mm_ram_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,

    // instruction port
    input  wire logic        instr_req_i,
    input  wire ram_addr_t   instr_addr_i,
    output      instr_word_t instr_rdata_o,
    output      logic        instr_rvalid_o,
    output      logic        instr_gnt_o,

    // data port
    input  wire logic        data_req_i,
    input  wire bus_addr_t   data_addr_i,
    input  wire logic        data_we_i,
    input  wire byte_en_t    data_be_i,
    input  wire data_word_t  data_wdata_i,
    output      data_word_t  data_rdata_o,
    output      logic        data_rvalid_o,
    output      logic        data_gnt_o,

    // timer interrupt
    input  wire irq_id_t     irq_id_i,
    input  wire logic        irq_ack_i,
    output      logic        irq_o,

    // test status
    output      logic        tests_passed_o,
    output      logic        tests_failed_o,
    output      logic        exit_valid_o,
    output      data_word_t  exit_value_o
);

    logic       instr_rvalid_q;

    // decoder to RAM
    logic       ram_req;
    ram_addr_t  ram_addr;
    logic       ram_we;
    byte_en_t   ram_be;
    data_word_t ram_wdata;
    data_word_t ram_rdata;

    // decoder to timer and response logic
    logic       timer_mask_we;
    logic       timer_cnt_we;
    data_word_t timer_wdata;
    rdata_sel_e rdata_sel;

    // fetches are always granted, data comes back next cycle
    assign instr_gnt_o = instr_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i;
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;

    dp_ram dp_ram_i (
        .clk_i         (clk_i),
        .instr_req_i   (instr_req_i),
        .instr_addr_i  (instr_addr_i),
        .instr_rdata_o (instr_rdata_o),
        .data_req_i    (ram_req),
        .data_addr_i   (ram_addr),
        .data_we_i     (ram_we),
        .data_be_i     (ram_be),
        .data_wdata_i  (ram_wdata),
        .data_rdata_o  (ram_rdata)
    );

    mm_addr_decoder mm_addr_decoder_i (
        .data_req_i      (data_req_i),
        .data_we_i       (data_we_i),
        .data_addr_i     (data_addr_i),
        .data_be_i       (data_be_i),
        .data_wdata_i    (data_wdata_i),
        .ram_req_o       (ram_req),
        .ram_addr_o      (ram_addr),
        .ram_we_o        (ram_we),
        .ram_be_o        (ram_be),
        .ram_wdata_o     (ram_wdata),
        .timer_mask_we_o (timer_mask_we),
        .timer_cnt_we_o  (timer_cnt_we),
        .timer_wdata_o   (timer_wdata),
        .rdata_sel_o     (rdata_sel),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o)
    );

    tb_timer tb_timer_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .mask_we_i (timer_mask_we),
        .cnt_we_i  (timer_cnt_we),
        .wdata_i   (timer_wdata),
        .irq_ack_i (irq_ack_i),
        .irq_id_i  (irq_id_i),
        .irq_o     (irq_o)
    );

    data_resp_ctrl data_resp_ctrl_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_req_i    (data_req_i),
        .rdata_sel_i   (rdata_sel),
        .ram_rdata_i   (ram_rdata),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// ==========================================================================
// free running testbench clock and an active low reset held a few cycles
// ==========================================================================

`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

    // reset is released on a rising edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/mm_ram_tb.sv */
// ==========================================================================
// self-checking testbench for the memory wrapper; a byte model of the RAM
// and queues of expected responses feed the assertions
// ==========================================================================

`default_nettype none
`timescale 1ns/100ps

`include "mm_ram_consts.svh"

module mm_ram_tb import mm_ram_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int RST_CYCLES      = 5;
    localparam int RAM_BYTES       = 2 ** `RAM_ADDR_WIDTH;
    localparam int WINDOW_BYTES    = 256;
    localparam int FILL_BYTES      = WINDOW_BYTES + 16;
    localparam int N_WRITES        = 48;
    localparam int N_FETCH         = 24;
    localparam int TIMER_COUNT     = 20;
    localparam int STIM_CYCLES     = RST_CYCLES + FILL_BYTES / 4 + 2 * N_WRITES + N_FETCH
                                     + 3 * TIMER_COUNT + 40;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES + 100;

    logic        clk;
    logic        rst_n;
    logic        instr_req_i;
    ram_addr_t   instr_addr_i;
    instr_word_t instr_rdata_o;
    logic        instr_rvalid_o;
    logic        instr_gnt_o;
    logic        data_req_i;
    bus_addr_t   data_addr_i;
    logic        data_we_i;
    byte_en_t    data_be_i;
    data_word_t  data_wdata_i;
    data_word_t  data_rdata_o;
    logic        data_rvalid_o;
    logic        data_gnt_o;
    irq_id_t     irq_id_i;
    logic        irq_ack_i;
    logic        irq_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        exit_valid_o;
    data_word_t  exit_value_o;

    // reference model and expected responses
    logic [7:0]  ref_mem [0:RAM_BYTES-1];
    data_word_t  data_exp_q[$];
    instr_word_t instr_exp_q[$];
    bus_addr_t   wr_addr_q[$];
    data_word_t  exp_data;
    instr_word_t exp_instr;
    logic        irq_exp;
    int          value_errors;
    int          protocol_errors;

    logic        status_wr;
    logic        exit_wr;
    logic        exp_passed;
    logic        exp_failed;
    data_word_t  exp_exit_value;

    assign status_wr      = data_req_i && data_we_i && (data_addr_i == `ADDR_STATUS);
    assign exit_wr        = data_req_i && data_we_i && (data_addr_i == `ADDR_EXIT);
    assign exp_passed     = status_wr && (data_wdata_i == `STATUS_PASS_VALUE);
    assign exp_failed     = status_wr && (data_wdata_i == `STATUS_FAIL_VALUE);
    assign exp_exit_value = exit_wr ? data_wdata_i : '0;

    tb_clk_gen #(
        .PERIOD_NS  (CLK_PERIOD),
        .RST_CYCLES (RST_CYCLES)
    ) tb_clk_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    mm_ram mm_ram_inst (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_rdata_o  (instr_rdata_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_gnt_o    (instr_gnt_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_rdata_o   (data_rdata_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_gnt_o     (data_gnt_o),
        .irq_id_i       (irq_id_i),
        .irq_ack_i      (irq_ack_i),
        .irq_o          (irq_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    task automatic report_mismatch(input string test, input logic [127:0] exp,
                                   input logic [127:0] act);
        value_errors++;
        $display("FAILED %s: expected %0h, actual %0h at %0t", test, exp, act, $time);
    endtask

    task automatic report_protocol_error(input string what);
        protocol_errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    // handshake timing
    assert property (@(posedge clk) disable iff (!rst_n) data_gnt_o == data_req_i)
        else report_protocol_error("data grant differs from data request");
    assert property (@(posedge clk) disable iff (!rst_n) instr_gnt_o == instr_req_i)
        else report_protocol_error("instruction grant differs from instruction request");
    assert property (@(posedge clk) disable iff (!rst_n) data_rvalid_o == $past(data_req_i))
        else report_protocol_error("data rvalid not one cycle after its request");
    assert property (@(posedge clk) disable iff (!rst_n) instr_rvalid_o == $past(instr_req_i))
        else report_protocol_error("instruction rvalid not one cycle after its request");

    // status pulses and timer interrupt
    assert property (@(posedge clk) disable iff (!rst_n) tests_passed_o == exp_passed)
        else report_mismatch("pass pulse", $sampled(exp_passed), $sampled(tests_passed_o));
    assert property (@(posedge clk) disable iff (!rst_n) tests_failed_o == exp_failed)
        else report_mismatch("fail pulse", $sampled(exp_failed), $sampled(tests_failed_o));
    assert property (@(posedge clk) disable iff (!rst_n) exit_valid_o == exit_wr)
        else report_mismatch("exit valid", $sampled(exit_wr), $sampled(exit_valid_o));
    assert property (@(posedge clk) disable iff (!rst_n) exit_value_o == exp_exit_value)
        else report_mismatch("exit value", $sampled(exp_exit_value), $sampled(exit_value_o));
    assert property (@(posedge clk) disable iff (!rst_n) irq_o == irq_exp)
        else report_mismatch("timer irq", $sampled(irq_exp), $sampled(irq_o));

    // responses are checked on the falling edge between two driving edges
    always @(negedge clk) begin
        if (rst_n && data_rvalid_o) begin
            if (data_exp_q.size() == 0) begin
                report_protocol_error("data response without an outstanding request");
            end else begin
                exp_data = data_exp_q.pop_front();
                assert (data_rdata_o === exp_data)
                    else report_mismatch("data response", exp_data, data_rdata_o);
            end
        end
        if (rst_n && instr_rvalid_o) begin
            if (instr_exp_q.size() == 0) begin
                report_protocol_error("fetch response without an outstanding request");
            end else begin
                exp_instr = instr_exp_q.pop_front();
                assert (instr_rdata_o === exp_instr)
                    else report_mismatch("instruction fetch", exp_instr, instr_rdata_o);
            end
        end
    end

    function automatic data_word_t fill_word(input ram_addr_t addr);
        return {addr, ~addr} ^ 32'h5A5A_0000;
    endfunction

    function automatic data_word_t model_word(input bus_addr_t addr);
        int         base;
        data_word_t word;
        base = int'(addr[`RAM_ADDR_WIDTH-1:2]) * 4;
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = ref_mem[base + i];
        end
        return word;
    endfunction

    // lowest address lands in the least significant byte
    function automatic instr_word_t model_fetch(input ram_addr_t addr);
        instr_word_t fetch;
        for (int i = 0; i < 16; i++) begin
            fetch[8*i +: 8] = ref_mem[(int'(addr) + i) % RAM_BYTES];
        end
        return fetch;
    endfunction

    task automatic data_access(input logic we, input bus_addr_t addr, input byte_en_t be,
                               input data_word_t wdata);
        int base;
        @(posedge clk);
        data_req_i   <= 1'b1;
        data_we_i    <= we;
        data_addr_i  <= addr;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        base = int'(addr[`RAM_ADDR_WIDTH-1:2]) * 4;
        if (we) begin
            data_exp_q.push_back('0);
            if (addr < RAM_BYTES) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        ref_mem[base + i] = wdata[8*i +: 8];
                    end
                end
            end
        end else if (addr < RAM_BYTES) begin
            data_exp_q.push_back(model_word(addr));
        end else begin
            data_exp_q.push_back(`ERR_RDATA);
        end
    endtask

    task automatic fetch_instr(input ram_addr_t addr);
        @(posedge clk);
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        instr_exp_q.push_back(model_fetch(addr));
    endtask

    task automatic drive_idle();
        @(posedge clk);
        data_req_i  <= 1'b0;
        data_we_i   <= 1'b0;
        instr_req_i <= 1'b0;
    endtask

    // the interrupt is expected low after the edge that samples a matching ack
    task automatic ack_irq(input irq_id_t id, input logic clears);
        @(posedge clk);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk);
        irq_ack_i <= 1'b0;
        if (clears) begin
            irq_exp <= 1'b0;
        end
    endtask

    initial begin
        bus_addr_t wr_addr;
        void'($urandom(32'hbfdc_ba30));
        instr_req_i     = 1'b0;
        instr_addr_i    = '0;
        data_req_i      = 1'b0;
        data_addr_i     = '0;
        data_we_i       = 1'b0;
        data_be_i       = '0;
        data_wdata_i    = '0;
        irq_id_i        = '0;
        irq_ack_i       = 1'b0;
        irq_exp         = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;

        wait (rst_n === 1'b1);
        @(negedge clk);
        assert ({instr_rdata_o, instr_rvalid_o, instr_gnt_o, data_rdata_o, data_rvalid_o,
                 data_gnt_o, irq_o, tests_passed_o, tests_failed_o, exit_valid_o,
                 exit_value_o} === '0)
            else report_protocol_error("outputs not low after reset");

        // known contents followed by random byte writes and back to back reads
        for (int a = 0; a < FILL_BYTES; a += 4) begin
            data_access(1'b1, bus_addr_t'(a), 4'hF, fill_word(ram_addr_t'(a)));
        end
        repeat (N_WRITES) begin
            wr_addr = bus_addr_t'($urandom % WINDOW_BYTES) & ~32'h3;
            wr_addr_q.push_back(wr_addr);
            data_access(1'b1, wr_addr, byte_en_t'($urandom), $urandom);
        end
        foreach (wr_addr_q[i]) begin
            data_access(1'b0, wr_addr_q[i], '0, '0);
        end
        drive_idle();

        // fetches may start on any byte
        for (int i = 0; i < N_FETCH; i++) begin
            fetch_instr(ram_addr_t'(wr_addr_q[i]) + ram_addr_t'($urandom % 4));
        end
        drive_idle();

        data_access(1'b1, `ADDR_STATUS, 4'hF, `STATUS_PASS_VALUE);
        data_access(1'b1, `ADDR_STATUS, 4'hF, `STATUS_FAIL_VALUE);
        data_access(1'b1, `ADDR_STATUS, 4'hF, $urandom | 32'h8000_0000);
        data_access(1'b1, `ADDR_EXIT, 4'hF, $urandom);
        drive_idle();

        // with the mask bit set the interrupt rises TIMER_COUNT edges after the load
        data_access(1'b1, `ADDR_TIMER_MASK, 4'hF, 32'h1 << `TIMER_IRQ_ID);
        data_access(1'b1, `ADDR_TIMER_CNT, 4'hF, TIMER_COUNT);
        drive_idle();
        repeat (TIMER_COUNT) @(posedge clk);
        irq_exp <= 1'b1;
        ack_irq(irq_id_t'(7), 1'b0);
        ack_irq(irq_id_t'(`TIMER_IRQ_ID), 1'b1);

        // interrupt masked
        data_access(1'b1, `ADDR_TIMER_MASK, 4'hF, ~(32'h1 << `TIMER_IRQ_ID));
        data_access(1'b1, `ADDR_TIMER_CNT, 4'hF, TIMER_COUNT);
        drive_idle();
        repeat (TIMER_COUNT + 4) @(posedge clk);

        // unmapped accesses leave the RAM word under the truncated address untouched
        data_access(1'b0, 32'h3000_0000 | ($urandom & 32'h0FFF_FFFC), '0, '0);
        data_access(1'b1, 32'h4000_0010, 4'hF, $urandom);
        data_access(1'b0, 32'h0000_0010, '0, '0);
        drive_idle();
        repeat (3) @(posedge clk);

        if (data_exp_q.size() != 0 || instr_exp_q.size() != 0) begin
            report_protocol_error("responses missing at the end of the run");
        end
        $display("errors: %0d value mismatches, %0d protocol violations",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, stimulus did not complete",
                 WATCHDOG_CYCLES);
        $display("errors: %0d value mismatches, %0d protocol violations",
                 value_errors, protocol_errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
rtl/mm_ram_pkg.sv
rtl/dp_ram.sv
rtl/mm_addr_decoder.sv
rtl/tb_timer.sv
rtl/data_resp_ctrl.sv
rtl/mm_ram.sv
testbench/tb_clk_gen.sv
testbench/mm_ram_tb.sv
